// ==== hdl/ringPkg.sv ====
// Ring controller widths, opcode/state/select enums, ring and core message structs
package ringPkg;

    //==========================================================================
    // Sizes and widths
    //==========================================================================
    localparam int ENTRY_COUNT       = 4;  // F2C buffer depth
    localparam int ENTRY_INDEX_WIDTH = $clog2(ENTRY_COUNT);
    localparam int REQUESTOR_WIDTH   = 10;
    localparam int ADDRESS_WIDTH     = 32;
    localparam int DATA_WIDTH        = 32;

    // Target core lives in the top address byte
    localparam int CORE_ID_WIDTH = 8;
    localparam int CORE_ID_MSB   = 31;
    localparam int CORE_ID_LSB   = 24;

    localparam int VENTILATION_WIDTH = 2;
    localparam logic [VENTILATION_WIDTH-1:0] VENTILATION_LIMIT = 2'd3;  // F2C burst before bubble

    //==========================================================================
    // Enums
    //==========================================================================
    typedef enum logic [1:0] {
        RD       = 2'b00,
        RD_RSP   = 2'b01,
        WR       = 2'b10,
        WR_BCAST = 2'b11
    } opcodeT;

    // Per-entry F2C lifecycle
    typedef enum logic [2:0] {
        FREE       = 3'd0,
        WRITE      = 3'd1,
        READ       = 3'd2,
        READ_PRGRS = 3'd3,  // Read handed to core, awaiting data
        READ_RDY   = 3'd4   // Data back, waiting for the ring
    } entryStateT;

    typedef enum logic [1:0] {
        BUBBLE_OUT   = 2'd0,
        RING_INPUT   = 2'd1,
        F2C_RESPONSE = 2'd2
    } rspSelT;

    //==========================================================================
    // Message structs
    //==========================================================================
    typedef struct packed {
        logic                       valid;
        logic [REQUESTOR_WIDTH-1:0] requestor;
        opcodeT                     opcode;
        logic [ADDRESS_WIDTH-1:0]   address;
        logic [DATA_WIDTH-1:0]      data;
    } ringMsgT;

    typedef struct packed {
        logic                     valid;
        opcodeT                   opcode;
        logic [ADDRESS_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0]    data;
    } coreMsgT;

endpackage

// ==== hdl/ringIngress.sv ====
// Ring ingress: input registers, request classification, request output stage, response filter
`timescale 1ns/10ps

module ringIngress (
    input  logic                              QClk,
    input  logic                              reset,
    input  logic [ringPkg::CORE_ID_WIDTH-1:0] coreId,
    input  ringPkg::ringMsgT                  ringReqIn,
    input  ringPkg::ringMsgT                  ringRspIn,
    input  logic                              bufferFull,
    output ringPkg::ringMsgT                  allocReq,
    output ringPkg::ringMsgT                  rspIn,
    output ringPkg::ringMsgT                  ringReqOut
);

    ringPkg::ringMsgT reqQ;        // Request one cycle after the ring
    ringPkg::ringMsgT rspQ;        // Response one cycle after the ring
    ringPkg::ringMsgT reqOutNext;
    logic             reqIdMatch;
    logic             rspIdMatch;
    logic             isBroadcast;
    logic             forThisCore;
    logic             forwardReq;

    //==========================================================================
    // Ring input registers
    //==========================================================================
    always_ff @(posedge QClk) begin
        reqQ <= ringReqIn;
        rspQ <= ringRspIn;
        if (reset) begin
            reqQ.valid <= 1'b0;
            rspQ.valid <= 1'b0;
        end
    end

    //==========================================================================
    // Request classification
    //==========================================================================
    assign reqIdMatch  = (reqQ.address[ringPkg::CORE_ID_MSB:ringPkg::CORE_ID_LSB] == coreId);
    assign isBroadcast = (reqQ.opcode == ringPkg::WR_BCAST);

    // Responses on the request channel are never ours
    assign forThisCore = reqQ.valid && (reqQ.opcode != ringPkg::RD_RSP)
                         && (reqIdMatch || isBroadcast);

    // Full buffer pushes our own request one more lap
    assign forwardReq  = reqQ.valid && (!forThisCore || isBroadcast || bufferFull);

    assign rspIdMatch  = (rspQ.address[ringPkg::CORE_ID_MSB:ringPkg::CORE_ID_LSB] == coreId);

    always_comb begin
        allocReq         = reqQ;
        allocReq.valid   = forThisCore && !bufferFull;
        reqOutNext       = reqQ;
        reqOutNext.valid = forwardReq;
        rspIn            = rspQ;
        rspIn.valid      = rspQ.valid && !rspIdMatch;  // Consume responses for this core
    end

    //==========================================================================
    // Ring request output stage
    //==========================================================================
    always_ff @(posedge QClk) begin
        ringReqOut <= reqOutNext;
        if (reset) begin
            ringReqOut.valid <= 1'b0;
        end
    end

endmodule

// ==== hdl/f2cBuffer.sv ====
// F2C buffer: entry array, per-entry state machine, core request and response candidate select
`timescale 1ns/10ps

module f2cBuffer (
    input  logic              QClk,
    input  logic              reset,
    input  ringPkg::ringMsgT  allocReq,
    input  ringPkg::coreMsgT  coreRsp,
    input  logic              rspTaken,
    output logic              bufferFull,
    output ringPkg::coreMsgT  coreReq,
    output ringPkg::ringMsgT  rspCandidate
);

    ringPkg::entryStateT                   entryState     [ringPkg::ENTRY_COUNT];
    logic [ringPkg::REQUESTOR_WIDTH-1:0]   entryRequestor [ringPkg::ENTRY_COUNT];
    logic [ringPkg::ADDRESS_WIDTH-1:0]     entryAddress   [ringPkg::ENTRY_COUNT];
    logic [ringPkg::DATA_WIDTH-1:0]        entryData      [ringPkg::ENTRY_COUNT];

    logic [ringPkg::ENTRY_COUNT-1:0]       freeVec;
    logic [ringPkg::ENTRY_COUNT-1:0]       pendingVec;  // READ or WRITE, waiting for core
    logic [ringPkg::ENTRY_COUNT-1:0]       readyVec;
    logic [ringPkg::ENTRY_COUNT-1:0]       matchVec;
    logic [ringPkg::ENTRY_INDEX_WIDTH-1:0] allocIdx;
    logic [ringPkg::ENTRY_INDEX_WIDTH-1:0] coreIdx;
    logic [ringPkg::ENTRY_INDEX_WIDTH-1:0] rspIdx;
    logic [ringPkg::ENTRY_INDEX_WIDTH-1:0] matchIdx;
    logic [ringPkg::ENTRY_COUNT-1:0]       allocHit;
    logic [ringPkg::ENTRY_COUNT-1:0]       deliverHit;
    logic [ringPkg::ENTRY_COUNT-1:0]       matchHit;
    logic [ringPkg::ENTRY_COUNT-1:0]       takenHit;

    // Lowest set bit wins
    function automatic logic [ringPkg::ENTRY_INDEX_WIDTH-1:0] firstSet(
        input logic [ringPkg::ENTRY_COUNT-1:0] vec
    );
        logic [ringPkg::ENTRY_INDEX_WIDTH-1:0] index;
        index = '0;
        for (int i = ringPkg::ENTRY_COUNT - 1; i >= 0; i--) begin
            if (vec[i]) begin
                index = i[ringPkg::ENTRY_INDEX_WIDTH-1:0];
            end
        end
        return index;
    endfunction

    //==========================================================================
    // Entry scan and selection
    //==========================================================================
    always_comb begin : entryScan
        for (int i = 0; i < ringPkg::ENTRY_COUNT; i++) begin
            freeVec[i]    = (entryState[i] == ringPkg::FREE);
            pendingVec[i] = (entryState[i] == ringPkg::READ) || (entryState[i] == ringPkg::WRITE);
            readyVec[i]   = (entryState[i] == ringPkg::READ_RDY);
            // Read data returns by address match
            matchVec[i]   = coreRsp.valid && (coreRsp.opcode == ringPkg::RD_RSP)
                            && (entryState[i] == ringPkg::READ_PRGRS)
                            && (coreRsp.address == entryAddress[i]);
        end
    end

    assign allocIdx   = firstSet(freeVec);
    assign coreIdx    = firstSet(pendingVec);
    assign rspIdx     = firstSet(readyVec);
    assign matchIdx   = firstSet(matchVec);
    assign bufferFull = ~|freeVec;

    always_comb begin : entryHits
        for (int i = 0; i < ringPkg::ENTRY_COUNT; i++) begin
            allocHit[i]   = allocReq.valid && (allocIdx == i[ringPkg::ENTRY_INDEX_WIDTH-1:0]);
            deliverHit[i] = pendingVec[i] && (coreIdx == i[ringPkg::ENTRY_INDEX_WIDTH-1:0]);
            matchHit[i]   = matchVec[i] && (matchIdx == i[ringPkg::ENTRY_INDEX_WIDTH-1:0]);
            takenHit[i]   = rspTaken && readyVec[i]
                            && (rspIdx == i[ringPkg::ENTRY_INDEX_WIDTH-1:0]);
        end
    end

    //==========================================================================
    // Per-entry state machine
    //==========================================================================
    always_ff @(posedge QClk) begin
        for (int i = 0; i < ringPkg::ENTRY_COUNT; i++) begin
            if (reset) begin
                entryState[i] <= ringPkg::FREE;
            end else begin
                case (entryState[i])
                    ringPkg::FREE: if (allocHit[i]) begin
                        entryState[i] <= (allocReq.opcode == ringPkg::RD) ? ringPkg::READ
                                                                          : ringPkg::WRITE;
                    end
                    ringPkg::WRITE: if (deliverHit[i]) begin
                        entryState[i] <= ringPkg::FREE;  // Write done once core sees it
                    end
                    ringPkg::READ: if (deliverHit[i]) begin
                        entryState[i] <= ringPkg::READ_PRGRS;
                    end
                    ringPkg::READ_PRGRS: if (matchHit[i]) begin
                        entryState[i] <= ringPkg::READ_RDY;
                    end
                    ringPkg::READ_RDY: if (takenHit[i]) begin
                        entryState[i] <= ringPkg::FREE;
                    end
                    default: entryState[i] <= ringPkg::FREE;
                endcase
            end
        end
    end

    // Entry payload and captured read data
    always_ff @(posedge QClk) begin
        for (int i = 0; i < ringPkg::ENTRY_COUNT; i++) begin
            if (allocHit[i]) begin
                entryRequestor[i] <= allocReq.requestor;
                entryAddress[i]   <= allocReq.address;
                entryData[i]      <= allocReq.data;
            end else if (matchHit[i]) begin
                entryData[i]      <= coreRsp.data;
            end
        end
    end

    //==========================================================================
    // Core request and ring response candidate
    //==========================================================================
    always_comb begin
        coreReq.valid   = |pendingVec;
        coreReq.opcode  = (entryState[coreIdx] == ringPkg::READ) ? ringPkg::RD : ringPkg::WR;
        coreReq.address = entryAddress[coreIdx];
        coreReq.data    = entryData[coreIdx];

        rspCandidate.valid     = |readyVec;
        rspCandidate.requestor = entryRequestor[rspIdx];
        rspCandidate.opcode    = ringPkg::RD_RSP;
        rspCandidate.address   = entryAddress[rspIdx];
        rspCandidate.data      = entryData[rspIdx];
    end

endmodule

// ==== hdl/ringResponseArbiter.sv ====
// Ring response arbiter: output select, ventilation counter, response output register
`timescale 1ns/10ps

module ringResponseArbiter (
    input  logic             QClk,
    input  logic             reset,
    input  ringPkg::ringMsgT rspIn,
    input  ringPkg::ringMsgT rspCandidate,
    output logic             rspTaken,
    output ringPkg::ringMsgT ringRspOut
);

    ringPkg::rspSelT                       rspSel;
    ringPkg::ringMsgT                      rspNext;
    logic [ringPkg::VENTILATION_WIDTH-1:0] ventCount;  // Back-to-back F2C responses
    logic                                  needVent;

    //==========================================================================
    // Output select
    //==========================================================================
    assign needVent = (ventCount == ringPkg::VENTILATION_LIMIT);

    // Passing ring traffic always wins
    always_comb begin
        if (rspIn.valid) begin
            rspSel = ringPkg::RING_INPUT;
        end else if (needVent) begin
            rspSel = ringPkg::BUBBLE_OUT;
        end else if (rspCandidate.valid) begin
            rspSel = ringPkg::F2C_RESPONSE;
        end else begin
            rspSel = ringPkg::BUBBLE_OUT;
        end
    end

    assign rspTaken = (rspSel == ringPkg::F2C_RESPONSE);

    always_comb begin
        case (rspSel)
            ringPkg::RING_INPUT:   rspNext = rspIn;
            ringPkg::F2C_RESPONSE: rspNext = rspCandidate;
            default:               rspNext = '0;  // Bubble
        endcase
    end

    //==========================================================================
    // Ventilation counter
    //==========================================================================
    always_ff @(posedge QClk) begin
        if (reset) begin
            ventCount <= '0;
        end else begin
            case (rspSel)
                ringPkg::F2C_RESPONSE: ventCount <= ventCount + 1'b1;
                ringPkg::BUBBLE_OUT:   ventCount <= '0;
                default:               ventCount <= ventCount;  // Ring traffic holds count
            endcase
        end
    end

    //==========================================================================
    // Response output register
    //==========================================================================
    always_ff @(posedge QClk) begin
        ringRspOut <= rspNext;
        if (reset) begin
            ringRspOut.valid <= 1'b0;
        end
    end

endmodule

// ==== hdl/ringController.sv ====
// Ring controller top level: ingress, F2C buffer and response arbiter
`timescale 1ns/10ps

module ringController (
    input  logic                              QClk,
    input  logic                              reset,
    input  logic [ringPkg::CORE_ID_WIDTH-1:0] coreId,
    input  ringPkg::ringMsgT                  ringReqIn,
    input  ringPkg::ringMsgT                  ringRspIn,
    input  ringPkg::coreMsgT                  coreRsp,
    output ringPkg::ringMsgT                  ringReqOut,
    output ringPkg::ringMsgT                  ringRspOut,
    output ringPkg::coreMsgT                  coreReq
);

    ringPkg::ringMsgT allocReq;      // Accepted request for this core
    ringPkg::ringMsgT rspIn;         // Foreign ring response
    ringPkg::ringMsgT rspCandidate;  // Ready F2C read response
    logic             bufferFull;
    logic             rspTaken;

    ringIngress ringIngress_inst (
        .QClk       (QClk),
        .reset      (reset),
        .coreId     (coreId),
        .ringReqIn  (ringReqIn),
        .ringRspIn  (ringRspIn),
        .bufferFull (bufferFull),
        .allocReq   (allocReq),
        .rspIn      (rspIn),
        .ringReqOut (ringReqOut)
    );

    f2cBuffer f2cBuffer_inst (
        .QClk         (QClk),
        .reset        (reset),
        .allocReq     (allocReq),
        .coreRsp      (coreRsp),
        .rspTaken     (rspTaken),
        .bufferFull   (bufferFull),
        .coreReq      (coreReq),
        .rspCandidate (rspCandidate)
    );

    ringResponseArbiter ringResponseArbiter_inst (
        .QClk         (QClk),
        .reset        (reset),
        .rspIn        (rspIn),
        .rspCandidate (rspCandidate),
        .rspTaken     (rspTaken),
        .ringRspOut   (ringRspOut)
    );

endmodule

// ==== verification/ringControllerTb.sv ====
// Ring controller testbench: clock, reset, random stimulus, core responder, model and checks
`timescale 1ns/10ps

module ringControllerTb;

    localparam logic [ringPkg::CORE_ID_WIDTH-1:0] LOCAL_ID = 8'h5a;
    localparam int STIM_CYCLES = 62;  // Non-drain cycles of the six tests
    localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 200;

    logic             QClk;
    logic             reset;
    ringPkg::ringMsgT ringReqIn;
    ringPkg::ringMsgT ringRspIn;
    ringPkg::coreMsgT coreRsp;
    ringPkg::ringMsgT ringReqOut;
    ringPkg::ringMsgT ringRspOut;
    ringPkg::coreMsgT coreReq;

    int cycleCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testStart  = 0;
    int f2cRun     = 0;        // Back-to-back F2C responses seen
    bit responderOn;

    ringPkg::ringMsgT reqPipe[$];  // Expected ringReqOut, one per driven cycle
    ringPkg::ringMsgT rspPipe[$];  // Expected foreign ringRspOut
    ringPkg::ringMsgT coreExp[$];  // Accepted requests in delivery order
    ringPkg::ringMsgT f2cExp[$];   // Read responses still owed to the ring
    int               dueCycle[$];
    ringPkg::coreMsgT dueRsp[$];

    ringController ringController_inst (
        .QClk       (QClk),
        .reset      (reset),
        .coreId     (LOCAL_ID),
        .ringReqIn  (ringReqIn),
        .ringRspIn  (ringRspIn),
        .coreRsp    (coreRsp),
        .ringReqOut (ringReqOut),
        .ringRspOut (ringRspOut),
        .coreReq    (coreReq)
    );

    initial begin
        QClk = 1'b0;
        forever #2 QClk = ~QClk;
    end

    function automatic ringPkg::ringMsgT makeMsg(input ringPkg::opcodeT op,
                                                 input logic [ringPkg::CORE_ID_WIDTH-1:0] id);
        ringPkg::ringMsgT msg;
        logic [31:0]      r;
        r             = $urandom();
        msg.valid     = 1'b1;
        msg.requestor = r[ringPkg::REQUESTOR_WIDTH-1:0];
        msg.opcode    = op;
        r             = $urandom();
        msg.address   = {id, r[ringPkg::CORE_ID_LSB-1:0]};
        msg.data      = $urandom();
        return msg;
    endfunction

    function automatic logic [ringPkg::CORE_ID_WIDTH-1:0] otherId();
        logic [31:0] r;
        r = $urandom();
        if (r[7:0] == LOCAL_ID) begin
            r[0] = ~r[0];
        end
        return r[7:0];
    endfunction

    task automatic checkRing(input string name, input ringPkg::ringMsgT got,
                             input ringPkg::ringMsgT exp);
        checkCount++;
        assert (got.valid == exp.valid && (!exp.valid || got == exp)) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    // One ring cycle; full is the model's view of the F2C buffer
    task automatic driveCycle(input ringPkg::ringMsgT req, input bit full,
                              input ringPkg::ringMsgT rsp);
        ringPkg::ringMsgT fwdMsg;
        ringPkg::ringMsgT rspMsg;
        bit               mine;
        bit               bcast;
        @(posedge QClk);
        ringReqIn <= req;
        ringRspIn <= rsp;
        bcast  = (req.opcode == ringPkg::WR_BCAST);
        mine   = req.valid && req.opcode != ringPkg::RD_RSP
                 && (req.address[ringPkg::CORE_ID_MSB:ringPkg::CORE_ID_LSB] == LOCAL_ID || bcast);
        fwdMsg = req;
        fwdMsg.valid = req.valid && (!mine || bcast || full);
        rspMsg = rsp;
        rspMsg.valid = rsp.valid
                       && rsp.address[ringPkg::CORE_ID_MSB:ringPkg::CORE_ID_LSB] != LOCAL_ID;
        reqPipe.push_back(fwdMsg);
        rspPipe.push_back(rspMsg);
        if (mine && !full) begin
            coreExp.push_back(req);
        end
    endtask

    // Idle until every outstanding request is answered, then flush the pipes
    task automatic drain(input bit inject);
        ringPkg::ringMsgT rsp;
        while (coreExp.size() > 0 || f2cExp.size() > 0 || dueCycle.size() > 0) begin
            rsp = '0;
            if (inject && $urandom_range(0, 1) == 1) begin
                rsp = makeMsg(ringPkg::RD_RSP, otherId());
            end
            driveCycle(rsp == '0 ? '0 : '0, 1'b0, rsp);
        end
        repeat (3) driveCycle('0, 1'b0, '0);
    endtask

    task automatic finishTest(input string name);
        $display("test %s done, %0d errors", name, errorCount - testStart);
        testStart = errorCount;
    endtask

    //==========================================================================
    // Cycle counter and core responder
    //==========================================================================
    always @(posedge QClk) begin : coreResponder
        int pick;
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end else begin
            pick = -1;
            for (int i = dueCycle.size() - 1; i >= 0; i--) begin
                if (responderOn && dueCycle[i] <= cycleCount) pick = i;  // Oldest due first
            end
            if (pick >= 0) begin
                coreRsp <= dueRsp[pick];
                dueCycle.delete(pick);
                dueRsp.delete(pick);
            end else begin
                coreRsp <= '0;
            end
        end
    end

    //==========================================================================
    // Output monitor sampled mid-cycle
    //==========================================================================
    always @(negedge QClk) begin : outputMonitor
        ringPkg::ringMsgT exp;
        ringPkg::ringMsgT acc;
        ringPkg::coreMsgT rsp;
        ringPkg::opcodeT  expOp;
        int               hit;
        if (!reset && reqPipe.size() > 2) begin
            checkRing("ringReqOut", ringReqOut, reqPipe.pop_front());
            exp = rspPipe.pop_front();
            if (exp.valid) begin
                checkRing("ringRspOut", ringRspOut, exp);
                f2cRun = 0;
            end else if (ringRspOut.valid) begin
                hit = -1;
                for (int i = 0; i < f2cExp.size(); i++) begin
                    if (f2cExp[i].address == ringRspOut.address) hit = i;
                end
                checkCount++;
                assert (hit >= 0) else begin
                    $display("ring response output carries an unexpected message %h", ringRspOut);
                    errorCount++;
                end
                if (hit >= 0) begin
                    checkRing("ringRspOut", ringRspOut, f2cExp[hit]);
                    f2cExp.delete(hit);
                end
                f2cRun++;
                checkCount++;
                assert (f2cRun <= int'(ringPkg::VENTILATION_LIMIT)) else begin
                    $display("F2C responses ran %0d cycles without a bubble", f2cRun);
                    errorCount++;
                end
            end else begin
                f2cRun = 0;
            end
        end
        if (!reset && coreReq.valid) begin
            checkCount++;
            assert (coreExp.size() > 0) else begin
                $display("core request appeared with no request outstanding");
                errorCount++;
            end
            if (coreExp.size() > 0) begin
                acc   = coreExp.pop_front();
                expOp = (acc.opcode == ringPkg::RD) ? ringPkg::RD : ringPkg::WR;
                checkCount++;
                assert (coreReq.opcode == expOp && coreReq.address == acc.address
                        && (expOp == ringPkg::RD || coreReq.data == acc.data)) else begin
                    $display("mismatch coreReq: got %h expected op %h addr %h data %h",
                             coreReq, expOp, acc.address, acc.data);
                    errorCount++;
                end
                if (expOp == ringPkg::RD) begin
                    rsp.valid   = 1'b1;
                    rsp.opcode  = ringPkg::RD_RSP;
                    rsp.address = acc.address;
                    rsp.data    = $urandom();
                    dueCycle.push_back(cycleCount + $urandom_range(1, 6));
                    dueRsp.push_back(rsp);
                    acc.opcode = ringPkg::RD_RSP;
                    acc.data   = rsp.data;
                    f2cExp.push_back(acc);
                end
            end
        end
    end

    //==========================================================================
    // Test sequence
    //==========================================================================
    initial begin : stimulus
        logic [31:0] pick;
        void'($urandom(32'h21b34646));
        ringReqIn   = '0;
        ringRspIn   = '0;
        coreRsp     = '0;
        responderOn = 1'b1;
        reset       = 1'b1;
        repeat (2) @(posedge QClk);
        reset <= 1'b0;

        repeat (20) begin
            pick = $urandom_range(0, 2);  // RD, RD_RSP or WR
            driveCycle(makeMsg(ringPkg::opcodeT'(pick[1:0]), otherId()), 1'b0,
                       ($urandom_range(0, 1) == 1) ? makeMsg(ringPkg::RD_RSP, otherId()) : '0);
        end
        drain(1'b0);
        finishTest("forwarding");

        repeat (6) driveCycle(makeMsg(ringPkg::WR, LOCAL_ID), 1'b0, '0);
        drain(1'b0);
        finishTest("write delivery");

        // Ring responses for this core go along to show they are consumed
        repeat (3) driveCycle(makeMsg(ringPkg::RD, LOCAL_ID), 1'b0,
                              makeMsg(ringPkg::RD_RSP, LOCAL_ID));
        drain(1'b0);
        finishTest("read round trip");

        repeat (4) driveCycle(makeMsg(ringPkg::WR_BCAST,
                                      ($urandom_range(0, 1) == 1) ? LOCAL_ID : otherId()),
                              1'b0, '0);
        drain(1'b0);
        finishTest("broadcast");

        responderOn <= 1'b0;
        for (int i = 0; i < 5; i++) begin
            driveCycle(makeMsg(ringPkg::RD, LOCAL_ID), i == 4, '0);  // Fifth finds it full
        end
        repeat (8) driveCycle('0, 1'b0, '0);
        responderOn <= 1'b1;
        drain(1'b0);
        finishTest("full buffer");

        // Held answers come back on consecutive cycles
        responderOn <= 1'b0;
        repeat (4) driveCycle(makeMsg(ringPkg::RD, LOCAL_ID), 1'b0, '0);
        repeat (8) driveCycle('0, 1'b0, '0);
        responderOn <= 1'b1;
        drain(1'b0);
        repeat (4) driveCycle(makeMsg(ringPkg::RD, LOCAL_ID), 1'b0, '0);
        drain(1'b1);
        finishTest("ventilation and priority");

        $display("tests 6, checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== ringController.f ====
hdl/ringPkg.sv
hdl/ringIngress.sv
hdl/f2cBuffer.sv
hdl/ringResponseArbiter.sv
hdl/ringController.sv
verification/ringControllerTb.sv
